/* mips_decode_cfg.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 decode configuration
// widths, instruction symbol codes, format and function class codes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_DECODE_CFG_SVH
`define MIPS_DECODE_CFG_SVH

`define MIPS_WORD_W   32
`define MIPS_REG_W    5
`define MIPS_SYM_W    6
`define MIPS_FORMAT_W 2
`define MIPS_FUNC_W   3

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction symbols
`define SYM_NOP     6'd0
`define SYM_ADD     6'd1
`define SYM_SUB     6'd2
`define SYM_ADDU    6'd3
`define SYM_SUBU    6'd4
`define SYM_AND     6'd5
`define SYM_OR      6'd6
`define SYM_XOR     6'd7
`define SYM_NOR     6'd8
`define SYM_SLT     6'd9
`define SYM_SLTU    6'd10
`define SYM_SLL     6'd11
`define SYM_SLLV    6'd12
`define SYM_SRL     6'd13
`define SYM_SRLV    6'd14
`define SYM_SRA     6'd15
`define SYM_SRAV    6'd16
`define SYM_CLO     6'd17
`define SYM_CLZ     6'd18
`define SYM_ADDI    6'd19
`define SYM_ADDIU   6'd20
`define SYM_ANDI    6'd21
`define SYM_ORI     6'd22
`define SYM_XORI    6'd23
`define SYM_LUI     6'd24
`define SYM_SLTI    6'd25
`define SYM_SLTIU   6'd26
`define SYM_LW      6'd27
`define SYM_LH      6'd28
`define SYM_LHU     6'd29
`define SYM_LB      6'd30
`define SYM_LBU     6'd31
`define SYM_SW      6'd32
`define SYM_SH      6'd33
`define SYM_SB      6'd34
`define SYM_BEQ     6'd35
`define SYM_BNE     6'd36
`define SYM_BLEZ    6'd37
`define SYM_BGTZ    6'd38
`define SYM_BGEZ    6'd39
`define SYM_BLTZ    6'd40
`define SYM_BGEZAL  6'd41
`define SYM_BLTZAL  6'd42
`define SYM_J       6'd43
`define SYM_JAL     6'd44
`define SYM_JR      6'd45
`define SYM_JALR    6'd46
`define SYM_MULT    6'd47
`define SYM_MULTU   6'd48
`define SYM_DIV     6'd49
`define SYM_DIVU    6'd50
`define SYM_MFHI    6'd51
`define SYM_MFLO    6'd52
`define SYM_MTHI    6'd53
`define SYM_MTLO    6'd54
`define SYM_MADD    6'd55
`define SYM_MADDU   6'd56
`define SYM_MSUB    6'd57
`define SYM_MSUBU   6'd58
`define SYM_INVALID 6'd63

//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encoding format
`define FORMAT_R 2'd0
`define FORMAT_I 2'd1
`define FORMAT_J 2'd2

// function class
`define FUNC_CALC_R    3'd0
`define FUNC_CALC_I    3'd1
`define FUNC_MEM_READ  3'd2
`define FUNC_MEM_WRITE 3'd3
`define FUNC_BRANCH    3'd4
`define FUNC_JUMP      3'd5
`define FUNC_MULTDIV   3'd6
`define FUNC_OTHER     3'd7

`endif

/* mips_decode_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 decode types
// vector types and the decoded instruction bundle passed into ID/EX
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_decode_cfg.svh"

package mips_decode_pkg;

    typedef logic [`MIPS_WORD_W-1:0]   word_t;
    typedef logic [`MIPS_REG_W-1:0]    reg_idx_t;
    typedef logic [`MIPS_SYM_W-1:0]    symbol_t;
    typedef logic [`MIPS_FORMAT_W-1:0] format_t;
    typedef logic [`MIPS_FUNC_W-1:0]   func_t;

    typedef struct packed {
        symbol_t     sym;
        format_t     format;
        func_t       func;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic        rs_used;
        logic        rt_used;
        reg_idx_t    dest;     // 0 when nothing is written
        logic        dest_we;
        logic [15:0] imm16;    // raw field, no extension
    } decoded_t;

endpackage

/* instr_decoder.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder, raw MIPS32 word to instruction symbol
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_decode_cfg.svh"

module instr_decoder (
    input  mips_decode_pkg::word_t   instr_word,
    output mips_decode_pkg::symbol_t sym
);
    logic [5:0]                opcode;
    logic [5:0]                funct;
    logic [4:0]                shamt;
    mips_decode_pkg::reg_idx_t rt;
    mips_decode_pkg::symbol_t  special_sym;
    mips_decode_pkg::symbol_t  special2_sym;
    mips_decode_pkg::symbol_t  regimm_sym;

    assign opcode = instr_word[31:26];
    assign rt     = instr_word[20:16];
    assign shamt  = instr_word[10:6];
    assign funct  = instr_word[5:0];

    // SPECIAL, by funct
    always_comb begin
        case (funct)
            6'h00: special_sym = `SYM_SLL;
            6'h02: special_sym = `SYM_SRL;
            6'h03: special_sym = `SYM_SRA;
            6'h04: special_sym = `SYM_SLLV;
            6'h06: special_sym = `SYM_SRLV;
            6'h07: special_sym = `SYM_SRAV;
            6'h08: special_sym = `SYM_JR;
            6'h09: special_sym = `SYM_JALR;
            6'h10: special_sym = `SYM_MFHI;
            6'h11: special_sym = `SYM_MTHI;
            6'h12: special_sym = `SYM_MFLO;
            6'h13: special_sym = `SYM_MTLO;
            6'h18: special_sym = `SYM_MULT;
            6'h19: special_sym = `SYM_MULTU;
            6'h1a: special_sym = `SYM_DIV;
            6'h1b: special_sym = `SYM_DIVU;
            6'h20: special_sym = `SYM_ADD;
            6'h21: special_sym = `SYM_ADDU;
            6'h22: special_sym = `SYM_SUB;
            6'h23: special_sym = `SYM_SUBU;
            6'h24: special_sym = `SYM_AND;
            6'h25: special_sym = `SYM_OR;
            6'h26: special_sym = `SYM_XOR;
            6'h27: special_sym = `SYM_NOR;
            6'h2a: special_sym = `SYM_SLT;
            6'h2b: special_sym = `SYM_SLTU;
            default: special_sym = `SYM_INVALID;
        endcase
    end

    // SPECIAL2, by funct
    always_comb begin
        case (funct)
            6'h00: special2_sym = `SYM_MADD;
            6'h01: special2_sym = `SYM_MADDU;
            6'h04: special2_sym = `SYM_MSUB;
            6'h05: special2_sym = `SYM_MSUBU;
            6'h20: special2_sym = `SYM_CLZ;
            6'h21: special2_sym = `SYM_CLO;
            default: special2_sym = `SYM_INVALID;
        endcase
    end

    // REGIMM, by rt
    always_comb begin
        case (rt)
            5'h00: regimm_sym = `SYM_BLTZ;
            5'h01: regimm_sym = `SYM_BGEZ;
            5'h10: regimm_sym = `SYM_BLTZAL;
            5'h11: regimm_sym = `SYM_BGEZAL;
            default: regimm_sym = `SYM_INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            6'h00: begin
                if (instr_word == '0)
                    sym = `SYM_NOP;                 // ahead of SLL
                else if (funct[5:2] != 4'b0000 && shamt != 5'd0)
                    sym = `SYM_INVALID;             // shamt only for immediate shifts
                else
                    sym = special_sym;
            end
            6'h01: sym = regimm_sym;
            6'h02: sym = `SYM_J;
            6'h03: sym = `SYM_JAL;
            6'h04: sym = `SYM_BEQ;
            6'h05: sym = `SYM_BNE;
            6'h06: sym = `SYM_BLEZ;
            6'h07: sym = `SYM_BGTZ;
            6'h08: sym = `SYM_ADDI;
            6'h09: sym = `SYM_ADDIU;
            6'h0a: sym = `SYM_SLTI;
            6'h0b: sym = `SYM_SLTIU;
            6'h0c: sym = `SYM_ANDI;
            6'h0d: sym = `SYM_ORI;
            6'h0e: sym = `SYM_XORI;
            6'h0f: sym = `SYM_LUI;
            6'h1c: sym = special2_sym;
            6'h20: sym = `SYM_LB;
            6'h21: sym = `SYM_LH;
            6'h23: sym = `SYM_LW;
            6'h24: sym = `SYM_LBU;
            6'h25: sym = `SYM_LHU;
            6'h28: sym = `SYM_SB;
            6'h29: sym = `SYM_SH;
            6'h2b: sym = `SYM_SW;
            default: sym = `SYM_INVALID;
        endcase
    end

endmodule

/* instr_classifier.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction classifier, symbol to encoding format and function class
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_decode_cfg.svh"

module instr_classifier (
    input  mips_decode_pkg::symbol_t sym,
    output mips_decode_pkg::format_t format,
    output mips_decode_pkg::func_t   func
);
    logic r, i, j;
    logic calc_r, calc_i, mem_r, mem_w, br, jmp, md;

    // format groups
    assign r = sym inside {`SYM_NOP, `SYM_ADD, `SYM_SUB, `SYM_ADDU, `SYM_SUBU, `SYM_AND,
                           `SYM_OR, `SYM_XOR, `SYM_NOR, `SYM_SLT, `SYM_SLTU, `SYM_SLL,
                           `SYM_SLLV, `SYM_SRL, `SYM_SRLV, `SYM_SRA, `SYM_SRAV,
                           `SYM_CLO, `SYM_CLZ};
    assign i = sym inside {`SYM_ADDI, `SYM_ADDIU, `SYM_ANDI, `SYM_ORI, `SYM_XORI, `SYM_LUI,
                           `SYM_SLTI, `SYM_SLTIU, `SYM_LW, `SYM_LH, `SYM_LHU, `SYM_LB,
                           `SYM_LBU, `SYM_SW, `SYM_SH, `SYM_SB, `SYM_BEQ, `SYM_BNE,
                           `SYM_BLEZ, `SYM_BGTZ, `SYM_BGEZ, `SYM_BLTZ,
                           `SYM_BGEZAL, `SYM_BLTZAL};
    assign j = sym inside {`SYM_J, `SYM_JAL};

    // JR, JALR, mult/div and invalid fall through to R
    assign format = r ? `FORMAT_R :
                    i ? `FORMAT_I :
                    j ? `FORMAT_J :
                        `FORMAT_R;

    // function class groups
    assign calc_r = sym inside {`SYM_NOP, `SYM_ADD, `SYM_SUB, `SYM_ADDU, `SYM_SUBU,
                                `SYM_AND, `SYM_OR, `SYM_XOR, `SYM_NOR, `SYM_SLT,
                                `SYM_SLTU, `SYM_SLL, `SYM_SRL, `SYM_SRA, `SYM_SLLV,
                                `SYM_SRLV, `SYM_SRAV, `SYM_CLO, `SYM_CLZ};
    assign calc_i = sym inside {`SYM_ADDI, `SYM_ADDIU, `SYM_ANDI, `SYM_ORI, `SYM_XORI,
                                `SYM_LUI, `SYM_SLTI, `SYM_SLTIU};
    assign mem_r  = sym inside {`SYM_LW, `SYM_LH, `SYM_LHU, `SYM_LB, `SYM_LBU};
    assign mem_w  = sym inside {`SYM_SW, `SYM_SH, `SYM_SB};
    assign br     = sym inside {`SYM_BEQ, `SYM_BNE, `SYM_BGEZ, `SYM_BGTZ, `SYM_BLEZ,
                                `SYM_BLTZ, `SYM_BGEZAL, `SYM_BLTZAL};
    assign jmp    = sym inside {`SYM_J, `SYM_JAL, `SYM_JALR, `SYM_JR};
    assign md     = sym inside {`SYM_MULT, `SYM_MULTU, `SYM_DIV, `SYM_DIVU,
                                `SYM_MFHI, `SYM_MFLO, `SYM_MTHI, `SYM_MTLO,
                                `SYM_MADD, `SYM_MADDU, `SYM_MSUB, `SYM_MSUBU};

    assign func = calc_r ? `FUNC_CALC_R    :
                  calc_i ? `FUNC_CALC_I    :
                  mem_r  ? `FUNC_MEM_READ  :
                  mem_w  ? `FUNC_MEM_WRITE :
                  br     ? `FUNC_BRANCH    :
                  jmp    ? `FUNC_JUMP      :
                  md     ? `FUNC_MULTDIV   :
                           `FUNC_OTHER;     // includes SYM_INVALID

endmodule

/* operand_select.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// operand select, source register use and destination register per symbol
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_decode_cfg.svh"

module operand_select (
    input  mips_decode_pkg::word_t    instr_word,
    input  mips_decode_pkg::symbol_t  sym,
    input  mips_decode_pkg::format_t  format,
    input  mips_decode_pkg::func_t    func,
    output mips_decode_pkg::decoded_t dec
);
    mips_decode_pkg::reg_idx_t rd;

    assign rd = instr_word[15:11];

    always_comb begin
        dec.sym    = sym;
        dec.format = format;
        dec.func   = func;
        dec.rs     = instr_word[25:21];
        dec.rt     = instr_word[20:16];
        dec.imm16  = instr_word[15:0];

        // rs readers
        dec.rs_used = ((func inside {`FUNC_CALC_R, `FUNC_CALC_I, `FUNC_MULTDIV}) &&
                       !(sym inside {`SYM_NOP, `SYM_SLL, `SYM_SRL, `SYM_SRA, `SYM_LUI,
                                     `SYM_MFHI, `SYM_MFLO})) ||
                      (func inside {`FUNC_MEM_READ, `FUNC_MEM_WRITE, `FUNC_BRANCH}) ||
                      (sym inside {`SYM_JR, `SYM_JALR});

        // rt readers
        dec.rt_used = (func == `FUNC_CALC_R && format == `FORMAT_R &&
                       !(sym inside {`SYM_NOP, `SYM_CLO, `SYM_CLZ})) ||
                      (func == `FUNC_MEM_WRITE) ||
                      (sym inside {`SYM_BEQ, `SYM_BNE}) ||
                      (sym inside {`SYM_MULT, `SYM_MULTU, `SYM_DIV, `SYM_DIVU,
                                   `SYM_MADD, `SYM_MADDU, `SYM_MSUB, `SYM_MSUBU});

        dec.dest_we = 1'b1;
        if (func == `FUNC_CALC_R || sym inside {`SYM_JALR, `SYM_MFHI, `SYM_MFLO}) begin
            dec.dest = rd;
        end else if (func inside {`FUNC_CALC_I, `FUNC_MEM_READ}) begin
            dec.dest = dec.rt;
        end else if (sym inside {`SYM_JAL, `SYM_BGEZAL, `SYM_BLTZAL}) begin
            dec.dest = 5'd31;   // link register
        end else begin
            dec.dest    = '0;
            dec.dest_we = 1'b0;
        end
    end

endmodule

/* id_ex_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX pipeline register
// load-use hazard check against the held instruction, stall and bubble
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_decode_cfg.svh"

module id_ex_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mips_decode_pkg::decoded_t in_dec,
    input  logic                      in_valid,
    output mips_decode_pkg::decoded_t ex_bus,
    output logic                      ex_valid,
    output logic                      stall
);
    logic load_in_ex;
    logic hit_rs;
    logic hit_rt;
    logic accept;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load-use hazard

    // valid load in EX that writes a real register
    assign load_in_ex = ex_valid && ex_bus.func == `FUNC_MEM_READ &&
                        ex_bus.dest_we && ex_bus.dest != '0;

    assign hit_rs = in_dec.rs_used && in_dec.rs == ex_bus.dest;
    assign hit_rt = in_dec.rt_used && in_dec.rt == ex_bus.dest;

    assign stall  = in_valid && load_in_ex && (hit_rs || hit_rt);
    assign accept = in_valid && !stall;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline register

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_bus   <= '0;
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= accept;     // low on stall gives the bubble
            if (accept) begin
                ex_bus <= in_dec;
            end
        end
    end

endmodule

/* decode_stage.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 decode stage, decoder to classifier to operand select into ID/EX
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decode_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  mips_decode_pkg::word_t    instr_word,
    input  logic                      instr_valid,
    output mips_decode_pkg::decoded_t ex_bus,
    output logic                      ex_valid,
    output logic                      stall
);
    mips_decode_pkg::symbol_t  sym;
    mips_decode_pkg::format_t  format;
    mips_decode_pkg::func_t    func;
    mips_decode_pkg::decoded_t dec;

    instr_decoder decoder_i (
        .instr_word (instr_word),
        .sym        (sym)
    );

    instr_classifier classifier_i (
        .sym    (sym),
        .format (format),
        .func   (func)
    );

    operand_select operand_select_i (
        .instr_word (instr_word),
        .sym        (sym),
        .format     (format),
        .func       (func),
        .dec        (dec)
    );

    id_ex_stage id_ex_stage_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_dec   (dec),
        .in_valid (instr_valid),
        .ex_bus   (ex_bus),
        .ex_valid (ex_valid),
        .stall    (stall)
    );

endmodule

/* decode_stage_assert.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage assertions on reset, stall and bubble behaviour
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decode_stage_assert (
    input logic clk,
    input logic arst_n,
    input logic instr_valid,
    input logic ex_valid,
    input logic stall
);

    // nothing valid in EX while reset is held
    reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !ex_valid)
        else $error("ex_valid high during reset");

    // bubble after every stall cycle
    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (!arst_n) stall |=> !ex_valid)
        else $error("no bubble after stall");

    stall_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) !instr_valid |-> !stall)
        else $error("stall raised without instr_valid");

endmodule

bind decode_stage decode_stage_assert decode_stage_assert_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .ex_valid    (ex_valid),
    .stall       (stall)
);

/* decode_stage_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS32 decode stage testbench
// replays the stimulus table one row per cycle and checks ID/EX outputs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module decode_stage_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DELAY  = 5;
    localparam int SAMPLE_DELAY = 30;   // just before the next edge
    localparam int FIELDS       = 9;
    localparam int MAX_ROWS     = 64;

    logic                      clk;
    logic                      arst_n;
    mips_decode_pkg::word_t    instr_word;
    logic                      instr_valid;
    mips_decode_pkg::decoded_t ex_bus;
    logic                      ex_valid;
    logic                      stall;

    logic [31:0] stim_mem [0:FIELDS*MAX_ROWS-1];
    int          row_count;
    logic        stim_loaded;

    decode_stage decode_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_word  (instr_word),
        .instr_valid (instr_valid),
        .ex_bus      (ex_bus),
        .ex_valid    (ex_valid),
        .stall       (stall)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // compare one field, stop at the first mismatch
    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s mismatch, got %0h expected %0h",
                     $time, field, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence

    initial begin
        int                     base;
        mips_decode_pkg::word_t last_word;   // last word taken into ID/EX
        clk         = 1'b0;
        arst_n      = 1'b1;
        instr_word  = '0;
        instr_valid = 1'b0;
        stim_loaded = 1'b0;
        last_word   = '0;

        $readmemh("decode_stimulus.txt", stim_mem);
        row_count = 0;
        while (row_count < MAX_ROWS && stim_mem[row_count*FIELDS+1] !== 'x)
            row_count++;
        if (row_count == 0) begin
            $display("no stimulus rows could be read from decode_stimulus.txt");
            $display("RESULT: FAIL");
            $fatal(1, "empty stimulus");
        end
        stim_loaded = 1'b1;

        #2 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY arst_n = 1'b1;

        for (int r = 0; r < row_count; r++) begin
            base = r * FIELDS;
            @(posedge clk);
            #DRIVE_DELAY;
            instr_word  = stim_mem[base];
            instr_valid = stim_mem[base+1][0];
            #SAMPLE_DELAY;
            check_value($sformatf("row %0d ex_valid", r), ex_valid, stim_mem[base+2]);
            check_value($sformatf("row %0d stall", r), stall, stim_mem[base+3]);
            if (stim_mem[base+2][0]) begin   // bus fields only mean something when valid
                check_value($sformatf("row %0d sym", r), ex_bus.sym, stim_mem[base+4]);
                check_value($sformatf("row %0d format", r), ex_bus.format,
                            stim_mem[base+5]);
                check_value($sformatf("row %0d func", r), ex_bus.func, stim_mem[base+6]);
                check_value($sformatf("row %0d dest", r), ex_bus.dest, stim_mem[base+7]);
                check_value($sformatf("row %0d dest_we", r), ex_bus.dest_we,
                            stim_mem[base+8]);
                // raw fields of the accepted word
                check_value($sformatf("row %0d rs", r), ex_bus.rs, last_word[25:21]);
                check_value($sformatf("row %0d rt", r), ex_bus.rt, last_word[20:16]);
                check_value($sformatf("row %0d imm16", r), ex_bus.imm16,
                            last_word[15:0]);
            end
            if (stim_mem[base+1][0] && !stim_mem[base+3][0])
                last_word = stim_mem[base];
        end

        $display("RESULT: PASS");
        $finish;
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog

    initial begin
        wait (stim_loaded);
        #((row_count + 10) * CLK_PERIOD);
        $display("timeout, the stimulus rows did not complete in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

/* decode_stimulus.txt */
// word valid | expected: ex_valid stall sym format func dest dest_we (all hex)
// expected ex fields belong to the previous accepted row, stall to this row
00000000 0  0 0  00 0 0 00 0
00221820 1  0 0  00 0 0 00 0
20240005 1  1 0  01 0 0 03 1
8c260008 1  1 0  13 1 1 04 1
ac220004 1  1 0  1b 1 2 06 1
10220003 1  1 0  20 1 3 00 0
08000100 1  1 0  23 1 4 00 0
0c000200 1  1 0  2b 2 5 00 0
03e00008 1  1 0  2c 2 5 1f 1
00220018 1  1 0  2d 0 5 00 0
04300002 1  1 0  2f 0 6 00 0
fc000000 1  1 0  2a 1 4 1f 1
00000000 0  1 0  3f 0 7 00 0
8c250000 1  0 0  00 0 0 00 0
00a23820 1  1 1  1b 1 2 05 1
00a23820 1  0 0  00 0 0 00 0
8c250000 1  1 0  01 0 0 07 1
3c051234 1  1 0  1b 1 2 05 1
8c200000 1  1 0  18 1 1 05 1
00001820 1  1 0  1b 1 2 00 1
00000000 0  1 0  01 0 0 03 1
00000000 0  0 0  00 0 0 00 0

/* compile.f */
+incdir+.
mips_decode_pkg.sv
instr_decoder.sv
instr_classifier.sv
operand_select.sv
id_ex_stage.sv
decode_stage.sv
decode_stage_assert.sv
decode_stage_tb.sv
